// File: Bender.yml
package:
  name: jump_unit

sources:
  - hdl/jumpUnitPkg.sv
  - hdl/instructionPhaseSequencer.sv
  - hdl/jumpGroupDecoder.sv
  - hdl/registerFile.sv
  - hdl/branchResolver.sv
  - hdl/programCounter.sv
  - hdl/jumpUnitTop.sv
  - target: simulation
    files:
      - tb/jumpUnit_checker.sv
      - tb/jumpUnitTb.sv

// File: hdl/branchResolver.sv
`default_nettype none

module branchResolver (
	input  logic                               CLK,
	input  logic                               reset,
	input  jumpUnitPkg::phaseT                 phase,
	input  jumpUnitPkg::decodedT               decoded,
	input  logic [jumpUnitPkg::wordWidth-1:0]  regBData,
	input  logic [jumpUnitPkg::wordWidth-1:0]  pc,
	output jumpUnitPkg::resolvedT              resolved,
	output logic                               regWriteEn,
	output jumpUnitPkg::regIndex               regWriteAddr,
	output logic [jumpUnitPkg::wordWidth-1:0]  regWriteData
);

	jumpUnitPkg::flagsT flags;
	jumpUnitPkg::resolvedT nextResolved;
	logic [jumpUnitPkg::wordWidth-1:0] operandB;
	logic flagBit;
	logic condition;

	always_comb begin
		case (decoded.ccSelect)
			jumpUnitPkg::flagZ: flagBit = flags.z;
			jumpUnitPkg::flagC: flagBit = flags.c;
			jumpUnitPkg::flagN: flagBit = flags.n;
			jumpUnitPkg::flagV: flagBit = flags.v;
			default: flagBit = 1'b0;
		endcase
	end

	// unconditional jumps always pass.
	assign condition = ~decoded.ccApply | (flagBit ^ decoded.ccInvert);

	always_comb begin
		if (decoded.immSource) begin
			operandB = {{(jumpUnitPkg::wordWidth - 6){decoded.immOffset[5]}},
				decoded.immOffset};
		end else begin
			operandB = regBData;
		end
	end

	always_comb begin
		nextResolved.taken = decoded.isJump & condition;
		if (decoded.relative) begin
			nextResolved.target = pc + operandB;
		end else begin
			nextResolved.target = operandB;
		end
		nextResolved.writeReg = decoded.writeReg;
		nextResolved.writeAddr = decoded.writeAddr;
		nextResolved.writeData = {{(jumpUnitPkg::wordWidth - 8){1'b0}}, decoded.writeData};
		nextResolved.writeFlags = decoded.writeFlags;
		nextResolved.flagData = decoded.flagData;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			resolved <= '0;
		end else if (phase == jumpUnitPkg::phaseExecute) begin
			resolved <= nextResolved;
		end
	end

	// flags change at commit, together with the pc.
	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (phase == jumpUnitPkg::phaseCommit && resolved.writeFlags) begin
			flags <= resolved.flagData;
		end
	end

	assign regWriteEn = (phase == jumpUnitPkg::phaseCommit) & resolved.writeReg;
	assign regWriteAddr = resolved.writeAddr;
	assign regWriteData = resolved.writeData;

endmodule

`default_nettype wire

// File: hdl/instructionPhaseSequencer.sv
`default_nettype none

module instructionPhaseSequencer (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  instrValid,
	input  jumpUnitPkg::instrWord instr,
	output logic                  instrReady,
	output jumpUnitPkg::phaseT    phase,
	output jumpUnitPkg::instrWord latched
);

	jumpUnitPkg::phaseT nextPhase;
	logic transfer;

	assign transfer = instrValid & instrReady;

	// fetch waits for a transfer, the other phases step every cycle.
	always_comb begin
		case (phase)
			jumpUnitPkg::phaseFetch: begin
				if (transfer) begin
					nextPhase = jumpUnitPkg::phaseDecode;
				end else begin
					nextPhase = jumpUnitPkg::phaseFetch;
				end
			end
			jumpUnitPkg::phaseDecode: nextPhase = jumpUnitPkg::phaseExecute;
			jumpUnitPkg::phaseExecute: nextPhase = jumpUnitPkg::phaseCommit;
			jumpUnitPkg::phaseCommit: nextPhase = jumpUnitPkg::phaseFetch;
			default: nextPhase = jumpUnitPkg::phaseFetch;
		endcase
	end

	// ready is low in reset and high only in fetch.
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= jumpUnitPkg::phaseFetch;
			instrReady <= 1'b0;
		end else begin
			phase <= nextPhase;
			instrReady <= (nextPhase == jumpUnitPkg::phaseFetch);
		end
	end

	// word is held until the next acceptance.
	always_ff @(posedge CLK) begin
		if (transfer) begin
			latched <= instr;
		end
	end

endmodule

`default_nettype wire

// File: hdl/jumpGroupDecoder.sv
`default_nettype none

module jumpGroupDecoder (
	input  logic                  CLK,
	input  logic                  reset,
	input  jumpUnitPkg::phaseT    phase,
	input  jumpUnitPkg::instrWord latched,
	output jumpUnitPkg::decodedT  decoded,
	output jumpUnitPkg::regIndex  regBAddr
);

	jumpUnitPkg::decodedT nextDecoded;

	always_comb begin
		nextDecoded = '0;
		case (latched.generic.group)
			jumpUnitPkg::groupLoadImm: begin
				nextDecoded.writeReg = 1'b1;
				nextDecoded.writeAddr = latched.loadImm.target;
				nextDecoded.writeData = latched.loadImm.imm;
			end
			jumpUnitPkg::groupFlags: begin
				nextDecoded.writeFlags = 1'b1;
				nextDecoded.flagData = jumpUnitPkg::flagsT'(latched.generic.payload[3:0]);
			end
			jumpUnitPkg::groupJump: begin
				nextDecoded.isJump = 1'b1;
				nextDecoded.ccApply = latched.jump.ccApply;
				nextDecoded.ccInvert = latched.jump.ccInvert;
				nextDecoded.ccSelect = latched.jump.ccSelect;
				nextDecoded.regBAddr = latched.jump.operand[3:0];
				nextDecoded.immOffset = latched.jump.operand;
				case (latched.jump.mode)
					jumpUnitPkg::jmpAbsReg: nextDecoded.relative = 1'b0;
					jumpUnitPkg::jmpRelReg: nextDecoded.relative = 1'b1;
					jumpUnitPkg::jmpRelImm: begin
						nextDecoded.relative = 1'b1;
						nextDecoded.immSource = 1'b1;
					end
					// reserved mode only steps the pc.
					jumpUnitPkg::jmpReserved: nextDecoded = '0;
					default: nextDecoded = '0;
				endcase
			end
			// nop and unknown groups.
			jumpUnitPkg::groupNop: nextDecoded = '0;
			default: nextDecoded = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			decoded <= '0;
		end else if (phase == jumpUnitPkg::phaseDecode) begin
			decoded <= nextDecoded;
		end
	end

	// settled from the decode edge, so the read is stable in execute.
	assign regBAddr = decoded.regBAddr;

endmodule

`default_nettype wire

// File: hdl/jumpUnitPkg.sv
`default_nettype none

package jumpUnitPkg;

	// ########################################################################
	// widths and sizes.
	// ########################################################################

	localparam int wordWidth = 16;
	localparam int regCount = 16;

	typedef logic [3:0] regIndex;

	// instruction groups; anything else retires as a nop.
	localparam logic [3:0] groupNop = 4'd0;
	localparam logic [3:0] groupLoadImm = 4'd1;
	localparam logic [3:0] groupFlags = 4'd2;
	localparam logic [3:0] groupJump = 4'd3;

	// jump modes.
	localparam logic [1:0] jmpAbsReg = 2'd0;
	localparam logic [1:0] jmpRelReg = 2'd1;
	localparam logic [1:0] jmpRelImm = 2'd2;
	localparam logic [1:0] jmpReserved = 2'd3;

	// condition flag select codes.
	localparam logic [1:0] flagZ = 2'd0;
	localparam logic [1:0] flagC = 2'd1;
	localparam logic [1:0] flagN = 2'd2;
	localparam logic [1:0] flagV = 2'd3;

	// ########################################################################
	// instruction word and its views.
	// ########################################################################

	typedef struct packed {
		logic [3:0]  group;
		logic [11:0] payload;
	} genericView;

	typedef struct packed {
		logic [3:0] group;
		regIndex    target;
		logic [7:0] imm;
	} loadImmView;

	// operand is register B in register modes, signed offset in jmpRelImm.
	typedef struct packed {
		logic [3:0] group;
		logic [1:0] mode;
		logic       ccApply;
		logic       ccInvert;
		logic [1:0] ccSelect;
		logic [5:0] operand;
	} jumpView;

	typedef union packed {
		genericView generic;
		loadImmView loadImm;
		jumpView    jump;
	} instrWord;

	// bit order matches the low nibble of a flag-write payload.
	typedef struct packed {
		logic v;
		logic n;
		logic c;
		logic z;
	} flagsT;

	typedef enum logic [3:0] {
		phaseFetch   = 4'b0001,
		phaseDecode  = 4'b0010,
		phaseExecute = 4'b0100,
		phaseCommit  = 4'b1000
	} phaseT;

	// ########################################################################
	// stage records.
	// ########################################################################

	typedef struct packed {
		logic       isJump;
		logic       relative;
		logic       immSource;
		logic       ccApply;
		logic       ccInvert;
		logic [1:0] ccSelect;
		regIndex    regBAddr;
		logic [5:0] immOffset;
		logic       writeReg;
		regIndex    writeAddr;
		logic [7:0] writeData;
		logic       writeFlags;
		flagsT      flagData;
	} decodedT;

	typedef struct packed {
		logic                 taken;
		logic [wordWidth-1:0] target;
		logic                 writeReg;
		regIndex              writeAddr;
		logic [wordWidth-1:0] writeData;
		logic                 writeFlags;
		flagsT                flagData;
	} resolvedT;

	typedef struct packed {
		logic                 valid;
		logic [wordWidth-1:0] pc;
		logic [wordWidth-1:0] nextPc;
		logic                 taken;
	} retireT;

endpackage

`default_nettype wire

// File: hdl/jumpUnitTop.sv
`default_nettype none

module jumpUnitTop (
	input  logic                  CLK,
	input  logic                  reset,
	input  jumpUnitPkg::instrWord instr,
	input  logic                  instrValid,
	output logic                  instrReady,
	output jumpUnitPkg::retireT   retire
);

	// ########################################################################
	// stage wiring.
	// ########################################################################

	jumpUnitPkg::phaseT phase;
	jumpUnitPkg::instrWord latched;
	jumpUnitPkg::decodedT decoded;
	jumpUnitPkg::resolvedT resolved;
	jumpUnitPkg::regIndex regBAddr;
	jumpUnitPkg::regIndex regWriteAddr;
	logic [jumpUnitPkg::wordWidth-1:0] regBData;
	logic [jumpUnitPkg::wordWidth-1:0] regWriteData;
	logic [jumpUnitPkg::wordWidth-1:0] pc;
	logic regWriteEn;

	instructionPhaseSequencer u_sequencer (
		.CLK(CLK),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.phase(phase),
		.latched(latched)
	);

	jumpGroupDecoder u_decoder (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.latched(latched),
		.decoded(decoded),
		.regBAddr(regBAddr)
	);

	registerFile u_registerFile (
		.CLK(CLK),
		.reset(reset),
		.readAddr(regBAddr),
		.readData(regBData),
		.writeEn(regWriteEn),
		.writeAddr(regWriteAddr),
		.writeData(regWriteData)
	);

	branchResolver u_resolver (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.decoded(decoded),
		.regBData(regBData),
		.pc(pc),
		.resolved(resolved),
		.regWriteEn(regWriteEn),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData)
	);

	programCounter u_programCounter (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.resolved(resolved),
		.pc(pc),
		.retire(retire)
	);

endmodule

`default_nettype wire

// File: hdl/programCounter.sv
`default_nettype none

module programCounter (
	input  logic                               CLK,
	input  logic                               reset,
	input  jumpUnitPkg::phaseT                 phase,
	input  jumpUnitPkg::resolvedT              resolved,
	output logic [jumpUnitPkg::wordWidth-1:0]  pc,
	output jumpUnitPkg::retireT                retire
);

	logic [jumpUnitPkg::wordWidth-1:0] nextPc;

	// wraps at the word width.
	assign nextPc = resolved.taken ? resolved.target : pc + 1'b1;

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			retire <= '0;
		end else begin
			// valid is a single-cycle pulse.
			retire.valid <= 1'b0;
			if (phase == jumpUnitPkg::phaseCommit) begin
				pc <= nextPc;
				retire.valid <= 1'b1;
				retire.pc <= pc;
				retire.nextPc <= nextPc;
				retire.taken <= resolved.taken;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile (
	input  logic                               CLK,
	input  logic                               reset,
	input  jumpUnitPkg::regIndex               readAddr,
	output logic [jumpUnitPkg::wordWidth-1:0]  readData,
	input  logic                               writeEn,
	input  jumpUnitPkg::regIndex               writeAddr,
	input  logic [jumpUnitPkg::wordWidth-1:0]  writeData
);

	logic [jumpUnitPkg::wordWidth-1:0] regs [jumpUnitPkg::regCount];

	assign readData = regs[readAddr];

	// registers start from zero after reset.
	always_ff @(posedge CLK) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
hdl/jumpUnitPkg.sv
hdl/instructionPhaseSequencer.sv
hdl/jumpGroupDecoder.sv
hdl/registerFile.sv
hdl/branchResolver.sv
hdl/programCounter.sv
hdl/jumpUnitTop.sv
tb/jumpUnit_checker.sv
tb/jumpUnitTb.sv

// File: tb/jumpStim.txt
// columns: instruction word, expected nextPc, expected taken (all hex)
// flags and registers follow from the earlier lines
0000 0001 0
9000 0002 0
1340 0003 0
3003 0040 1
1505 0041 0
3405 0046 1
380A 0050 1
3830 0040 1
17FF 0041 0
3000 0000 1
3820 FFE0 1
381F FFFF 1
0000 0000 0
2001 0001 0
3A04 0005 1
3B04 0006 0
3A44 0007 0
3B44 000B 1
200C 000C 0
3A84 0010 1
3B84 0011 0
3AC4 0015 1
3BC4 0016 0
3A04 0017 0
2002 0018 0
3A44 001C 1
3C03 001D 0
3E0A 001E 0
3645 0023 1
2000 0024 0

// File: tb/jumpUnitTb.sv
`default_nettype none

module jumpUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int stimLines = 30;
	localparam int waitLimit = 20;

	logic CLK;
	logic reset;
	logic instrValid;
	logic instrReady;
	jumpUnitPkg::instrWord instr;
	jumpUnitPkg::retireT retire;

	// one instruction, its expected nextPc and its expected taken per line.
	logic [jumpUnitPkg::wordWidth-1:0] stim [3*stimLines];
	logic [jumpUnitPkg::wordWidth-1:0] expPc;
	logic [31:0] lfsr;
	logic [1:0] gap;
	int errors;
	int lineErrors;
	int passed;
	int failed;
	int waited;
	bit timedOut;

	jumpUnitTop u_jumpUnitTop (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.retire(retire)
	);

	bind jumpUnitTop jumpUnit_checker u_checker (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.retire(retire)
	);

	always #10 CLK = ~CLK;

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic stepCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic checkPc(input string name, input logic [jumpUnitPkg::wordWidth-1:0] actual,
			input logic [jumpUnitPkg::wordWidth-1:0] expected);
		if (actual !== expected) begin
			$display("** Error %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkTaken(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// ########################################################################
	// instruction source.
	// ########################################################################

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		lfsr = 32'ha9559ef7;
		expPc = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		timedOut = 1'b0;
		$readmemh("tb/jumpStim.txt", stim);
		repeat (10) stepCycle();
		reset = 1'b0;
		for (int i = 0; i < stimLines && !timedOut; i++) begin
			// idle gap of 0 to 3 cycles.
			repeat (2) begin
				lfsr = lfsrStep(lfsr);
				gap = {gap[0], lfsr[0]};
			end
			repeat (gap) stepCycle();
			instr = stim[3*i];
			instrValid = 1'b1;
			waited = 0;
			while (!instrReady && waited < waitLimit) begin
				stepCycle();
				waited++;
			end
			if (!instrReady) begin
				$display("instruction %0d was never accepted, instrReady stayed low", i);
				timedOut = 1'b1;
				failed++;
			end else begin
				// this edge is the acceptance edge.
				stepCycle();
				instrValid = 1'b0;
				waited = 0;
				while (!retire.valid && waited < waitLimit) begin
					stepCycle();
					waited++;
				end
				if (!retire.valid) begin
					$display("instruction %0d produced no retire record in time", i);
					timedOut = 1'b1;
					failed++;
				end else begin
					lineErrors = errors;
					checkPc("retire.pc", retire.pc, expPc);
					checkPc("retire.nextPc", retire.nextPc, stim[3*i+1]);
					checkTaken("retire.taken", retire.taken, stim[3*i+2][0]);
					if (errors == lineErrors) begin
						passed++;
					end else begin
						failed++;
					end
					$display("test %0d instr %h pc %h nextPc %h taken %b %s", i, stim[3*i],
						retire.pc, retire.nextPc, retire.taken,
						(errors == lineErrors) ? "ok" : "mismatch");
					expPc = stim[3*i+1];
				end
			end
		end
		if (u_jumpUnitTop.u_checker.failures != 0) begin
			$display("the bound checker saw %0d assertion failures",
				u_jumpUnitTop.u_checker.failures);
		end
		$display("tests passed %0d failed %0d", passed, failed);
		if (passed == stimLines && u_jumpUnitTop.u_checker.failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/jumpUnit_checker.sv
`default_nettype none

module jumpUnit_checker (
	input logic                CLK,
	input logic                reset,
	input jumpUnitPkg::phaseT  phase,
	input logic                instrValid,
	input logic                instrReady,
	input jumpUnitPkg::retireT retire
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;
	logic transfer;

	assign transfer = instrValid & instrReady;

	phaseOneHot: assert property (@(posedge CLK) disable iff (reset) $onehot(phase))
	else begin
		$error("phase is not one-hot");
		failures++;
	end

	readyInFetch: assert property (@(posedge CLK) disable iff (reset)
		instrReady |-> phase == jumpUnitPkg::phaseFetch)
	else begin
		$error("instrReady high outside fetch");
		failures++;
	end

	retirePulse: assert property (@(posedge CLK) disable iff (reset)
		retire.valid |=> !retire.valid)
	else begin
		$error("retire.valid high two cycles in a row");
		failures++;
	end

	// decode, execute, commit, then the record is visible.
	retireLatency: assert property (@(posedge CLK) disable iff (reset)
		transfer |-> ##1 !retire.valid [*3] ##1 retire.valid)
	else begin
		$error("retire.valid not four edges after the transfer");
		failures++;
	end

endmodule

`default_nettype wire
